//--- logic/mvau_params.svh
/*
 * Sizing macros for the streaming matrix-vector unit
 * Matrix dimensions, lane and PE counts, fold factors,
 * counter widths and signed word widths
 */
`ifndef MVAU_PARAMS_SVH
`define MVAU_PARAMS_SVH

// Matrix dimensions
`define MVAU_MATRIX_W 8
`define MVAU_MATRIX_H 4

// Parallelism: activation lanes and processing elements
`define MVAU_SIMD 2
`define MVAU_PE 2

// Folding, chunks per row and row groups per matrix
`define MVAU_SF (`MVAU_MATRIX_W / `MVAU_SIMD)
`define MVAU_NF (`MVAU_MATRIX_H / `MVAU_PE)

// Counter widths for the two folds
`define MVAU_SF_T 2
`define MVAU_NF_T 1

// Signed word widths
`define MVAU_TSRC_I 4
`define MVAU_TW 4
`define MVAU_TDST_I 16

`endif

//--- logic/mvau_data_pkg.sv
/*
 * Datapath types of the matrix-vector unit
 * Scalar activation, weight, product and accumulator words,
 * plus the packed chunk, weight row, weight tile and output word
 */
`include "mvau_params.svh"

package mvau_data_pkg;

   // Scalar words, all two's complement
   typedef logic signed [`MVAU_TSRC_I-1:0] act_t;
   typedef logic signed [`MVAU_TW-1:0] wgt_t;
   typedef logic signed [`MVAU_TSRC_I+`MVAU_TW-1:0] prod_t;
   typedef logic signed [`MVAU_TDST_I-1:0] acc_t;

   // One input chunk, lane 0 in the low bits
   typedef act_t [`MVAU_SIMD-1:0] act_chunk_t;

   // SIMD weights of one PE, lane order matches the chunk
   typedef wgt_t [`MVAU_SIMD-1:0] wgt_row_t;

   // Weight input of one cycle, PE 0 in the low bits
   typedef wgt_row_t [`MVAU_PE-1:0] wgt_tile_t;

   // One result per PE, PE 0 in the low bits
   typedef acc_t [`MVAU_PE-1:0] out_word_t;

endpackage

//--- logic/mvau_ctrl_pkg.sv
/*
 * Control types of the matrix-vector unit
 * Fold counters, sequencer states and the control bundle
 * sent to the input buffer and the PE array
 */
`include "mvau_params.svh"

package mvau_ctrl_pkg;

   typedef logic [`MVAU_SF_T-1:0] sf_cnt_t;
   typedef logic [`MVAU_NF_T-1:0] nf_cnt_t;

   // IDLE waits, FILL takes the first pass, REUSE replays the buffer
   typedef enum logic [1:0] {
      IDLE,
      FILL,
      REUSE
   } ctrl_state_t;

   typedef struct packed {
      logic    ib_wen;   // Store chunk and pass it through
      logic    ib_ren;   // Replay stored chunk
      logic    do_mvau;  // A step is active this cycle
      logic    sf_clr;   // Last chunk of a row group
      sf_cnt_t sf_cnt;   // Chunk index, also the buffer address
   } mvau_ctrl_t;

endpackage

//--- logic/mvau_stream_control.sv
/*
 * Sequencer of the matrix-vector unit
 * Chunk and row-group counters with a three-state FSM
 * Outputs are decoded straight from state and counters
 */
`timescale 1ns/1ps
`include "mvau_params.svh"

module mvau_stream_control (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_v,
   output mvau_ctrl_pkg::mvau_ctrl_t ctrl
);

   localparam mvau_ctrl_pkg::sf_cnt_t SF_LAST = mvau_ctrl_pkg::sf_cnt_t'(`MVAU_SF - 1);
   localparam mvau_ctrl_pkg::nf_cnt_t NF_LAST = mvau_ctrl_pkg::nf_cnt_t'(`MVAU_NF - 1);

   mvau_ctrl_pkg::ctrl_state_t state;
   mvau_ctrl_pkg::sf_cnt_t     sf_cnt;
   mvau_ctrl_pkg::nf_cnt_t     nf_cnt;

   logic first_step;
   logic reuse_step;
   logic last_chunk;

   // A first-pass step needs a chunk, a replay step happens every cycle
   assign first_step = (state == mvau_ctrl_pkg::IDLE || state == mvau_ctrl_pkg::FILL) && in_v;
   assign reuse_step = (state == mvau_ctrl_pkg::REUSE);
   assign last_chunk = (sf_cnt == SF_LAST);

   // Control bundle, no extra latency
   assign ctrl.ib_wen  = first_step;
   assign ctrl.ib_ren  = reuse_step;
   assign ctrl.do_mvau = first_step | reuse_step;
   assign ctrl.sf_clr  = (first_step | reuse_step) & last_chunk;
   assign ctrl.sf_cnt  = sf_cnt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= mvau_ctrl_pkg::IDLE;
         sf_cnt <= '0;
         nf_cnt <= '0;
      end else begin
         case (state)
            mvau_ctrl_pkg::IDLE, mvau_ctrl_pkg::FILL: begin
               if (in_v) begin
                  if (last_chunk) begin
                     sf_cnt <= '0;
                     // Replay only when more row groups remain
                     if (`MVAU_NF > 1) begin
                        state  <= mvau_ctrl_pkg::REUSE;
                        nf_cnt <= nf_cnt + 1'b1;
                     end else begin
                        state <= mvau_ctrl_pkg::IDLE;
                     end
                  end else begin
                     sf_cnt <= sf_cnt + 1'b1;
                     state  <= mvau_ctrl_pkg::FILL;
                  end
               end
            end
            mvau_ctrl_pkg::REUSE: begin
               if (last_chunk) begin
                  sf_cnt <= '0;
                  // Last row group done, ready for the next vector
                  if (nf_cnt == NF_LAST) begin
                     nf_cnt <= '0;
                     state  <= mvau_ctrl_pkg::IDLE;
                  end else begin
                     nf_cnt <= nf_cnt + 1'b1;
                  end
               end else begin
                  sf_cnt <= sf_cnt + 1'b1;
               end
            end
            default: begin
               state  <= mvau_ctrl_pkg::IDLE;
               sf_cnt <= '0;
               nf_cnt <= '0;
            end
         endcase
      end
   end

endmodule

//--- logic/mvau_inp_buffer.sv
/*
 * Activation buffer of the matrix-vector unit
 * BUF_LEN chunks, written on the first pass with write-through,
 * read combinationally on replay, output held when idle
 */
`timescale 1ns/1ps
`include "mvau_params.svh"

module mvau_inp_buffer #(
   parameter int BUF_LEN  = `MVAU_SF,
   parameter int BUF_ADDR = `MVAU_SF_T
) (
   input  logic                       clk,
   input  mvau_data_pkg::act_chunk_t  in,
   input  logic                       wr_en,
   input  logic                       rd_en,
   input  logic [BUF_ADDR-1:0]        addr,
   output mvau_data_pkg::act_chunk_t  out
);

   mvau_data_pkg::act_chunk_t mem [BUF_LEN];
   mvau_data_pkg::act_chunk_t last_out;

   // Store the chunk of the first pass
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[addr] <= in;
      end
   end

   // Remember the last value driven so the PE inputs stay quiet
   always_ff @(posedge clk) begin
      if (wr_en || rd_en) begin
         last_out <= out;
      end
   end

   // Write-through has priority, then replay
   always_comb begin
      if (wr_en) begin
         out = in;
      end else if (rd_en) begin
         out = mem[addr];
      end else begin
         out = last_out;
      end
   end

endmodule

//--- logic/mvu_pe.sv
/*
 * Processing element of the matrix-vector unit
 * SIMD signed multipliers and an adder tree in stage 1,
 * a wrapping accumulator with result capture in stage 2
 */
`timescale 1ns/1ps
`include "mvau_params.svh"

module mvu_pe (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      sf_clr,
   input  logic                      do_mvau,
   input  mvau_data_pkg::act_chunk_t in_act,
   input  mvau_data_pkg::wgt_row_t   in_wgt,
   output logic                      out_v,
   output mvau_data_pkg::acc_t       out
);

   mvau_data_pkg::prod_t prod [`MVAU_SIMD];
   mvau_data_pkg::acc_t  dot;

   // Stage 1 registers
   mvau_data_pkg::acc_t  dot_q;
   logic                 v_q;
   logic                 clr_q;

   // Stage 2 running sum
   mvau_data_pkg::acc_t  acc;

   // One signed multiplier per lane
   always_comb begin
      for (int i = 0; i < `MVAU_SIMD; i++) begin
         prod[i] = mvau_data_pkg::act_t'(in_act[i]) * mvau_data_pkg::wgt_t'(in_wgt[i]);
      end
   end

   // Adder tree over the lanes, each product sign-extended first
   always_comb begin
      dot = '0;
      for (int i = 0; i < `MVAU_SIMD; i++) begin
         dot = dot + mvau_data_pkg::acc_t'(prod[i]);
      end
   end

   // Stage 1, valid and clear follow the sum
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         v_q   <= 1'b0;
         clr_q <= 1'b0;
      end else begin
         v_q   <= do_mvau;
         clr_q <= do_mvau & sf_clr;
      end
   end

   // Sum only loads on active steps
   always_ff @(posedge clk) begin
      if (do_mvau) begin
         dot_q <= dot;
      end
   end

   // Stage 2
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc   <= '0;
         out_v <= 1'b0;
      end else begin
         out_v <= 1'b0;
         if (v_q) begin
            if (clr_q) begin
               // Row group complete, next group starts from zero
               acc   <= '0;
               out_v <= 1'b1;
            end else begin
               acc <= acc + dot_q;
            end
         end
      end
   end

   // Result register, holds until the next row group ends
   always_ff @(posedge clk) begin
      if (v_q && clr_q) begin
         out <= acc + dot_q;
      end
   end

endmodule

//--- logic/mvau_stream.sv
/*
 * Streaming matrix-vector unit, top level
 * Input registers, sequencer, activation buffer,
 * the PE array and the output combine
 */
`timescale 1ns/1ps
`include "mvau_params.svh"

module mvau_stream (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      in_v,
   input  mvau_data_pkg::act_chunk_t in_act,
   input  mvau_data_pkg::wgt_tile_t  in_wgt,
   output logic                      out_v,
   output mvau_data_pkg::out_word_t  out
);

   // Registered inputs
   logic                      in_v_reg;
   mvau_data_pkg::act_chunk_t in_act_reg;
   mvau_data_pkg::wgt_tile_t  in_wgt_reg;

   mvau_ctrl_pkg::mvau_ctrl_t ctrl;

   // Chunk seen by every PE
   mvau_data_pkg::act_chunk_t buf_act;

   // Per-PE strobes
   logic [`MVAU_PE-1:0]       pe_v;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_v_reg <= 1'b0;
      end else begin
         in_v_reg <= in_v;
      end
   end

   // Activation only matters with in_v, weights step every cycle
   always_ff @(posedge clk) begin
      if (in_v) begin
         in_act_reg <= in_act;
      end
      in_wgt_reg <= in_wgt;
   end

   mvau_stream_control ctrl_i (
      .clk   (clk),
      .rst_n (rst_n),
      .in_v  (in_v_reg),
      .ctrl  (ctrl)
   );

   mvau_inp_buffer #(
      .BUF_LEN  (`MVAU_SF),
      .BUF_ADDR (`MVAU_SF_T)
   ) inp_buf_i (
      .clk   (clk),
      .in    (in_act_reg),
      .wr_en (ctrl.ib_wen),
      .rd_en (ctrl.ib_ren),
      .addr  (ctrl.sf_cnt),
      .out   (buf_act)
   );

   // Same chunk for all PEs, one weight row each
   for (genvar p = 0; p < `MVAU_PE; p++) begin : g_pe
      mvu_pe pe_i (
         .clk     (clk),
         .rst_n   (rst_n),
         .sf_clr  (ctrl.sf_clr),
         .do_mvau (ctrl.do_mvau),
         .in_act  (buf_act),
         .in_wgt  (in_wgt_reg[p]),
         .out_v   (pe_v[p]),
         .out     (out[p])
      );
   end

   // All PEs finish together
   assign out_v = |pe_v;

endmodule

//--- testbench/mvau_stream_assert.sv
/*
 * Protocol assertions for the sequencer
 * Step model of the first pass and the replay,
 * buffer enables, replay window, chunk counter and clear placement
 */
`timescale 1ns/1ps
`include "mvau_params.svh"

module mvau_stream_assert (
   input logic                       clk,
   input logic                       rst_n,
   input logic                       in_v,
   input mvau_ctrl_pkg::mvau_ctrl_t  ctrl,
   input mvau_ctrl_pkg::ctrl_state_t state
);

   localparam int SF        = `MVAU_SF;
   localparam int VEC_STEPS = `MVAU_SF * `MVAU_NF;

   // Number of failed assertions so far
   int fail_cnt = 0;

   // Steps of the current vector, counted apart from the sequencer
   int vec_step;
   int chunk;

   assign chunk = vec_step % SF;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vec_step <= 0;
      end else if (ctrl.do_mvau) begin
         vec_step <= (vec_step == VEC_STEPS - 1) ? 0 : vec_step + 1;
      end
   end

   // First SF steps store, the later ones replay, never both at once
   enables_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      (ctrl.ib_wen == (ctrl.do_mvau && vec_step < SF)) &&
      (ctrl.ib_ren == (ctrl.do_mvau && vec_step >= SF)))
   else begin
      $error("ib_wen or ib_ren out of step with the pass");
      fail_cnt++;
   end

   // Source stays quiet while the buffer replays
   no_input_in_reuse: assert property (@(posedge clk) disable iff (!rst_n)
      (state == mvau_ctrl_pkg::REUSE) |-> !in_v)
   else begin
      $error("in_v high during REUSE");
      fail_cnt++;
   end

   // Chunk counter follows the step count and so stays below SF
   sf_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      ctrl.sf_cnt == chunk)
   else begin
      $error("sf_cnt out of step with the chunk count");
      fail_cnt++;
   end

   // Clear only on the last chunk of a row group
   clr_on_last_chunk: assert property (@(posedge clk) disable iff (!rst_n)
      ctrl.sf_clr |-> (ctrl.do_mvau && chunk == SF - 1))
   else begin
      $error("sf_clr away from the last chunk");
      fail_cnt++;
   end

endmodule

//--- testbench/mvau_stream_tb.sv
/*
 * Testbench of the streaming matrix-vector unit
 * Clock and reset, seeded random vectors and weight streams,
 * reference model with expected-result queue,
 * result monitor and watchdog
 */
`timescale 1ns/1ps
`include "mvau_params.svh"

module mvau_stream_tb;

   localparam int SF      = `MVAU_SF;
   localparam int NF      = `MVAU_NF;
   localparam int SIMD    = `MVAU_SIMD;
   localparam int PE      = `MVAU_PE;
   localparam int W       = `MVAU_MATRIX_W;
   localparam int H       = `MVAU_MATRIX_H;
   localparam int NUM_VEC = 12;
   localparam int RST_CYC = 16;

   logic                      clk;
   logic                      rst_n;
   logic                      in_v;
   mvau_data_pkg::act_chunk_t in_act;
   mvau_data_pkg::wgt_tile_t  in_wgt;
   logic                      out_v;
   mvau_data_pkg::out_word_t  out;

   // Operands of the vector in flight as plain integers
   int vec [W];
   int mat [H][W];

   // Expected words and the edge count at which each pulse is sampled
   mvau_data_pkg::out_word_t exp_q [$];
   int                       exp_cyc_q [$];

   int cyc    = 0;
   int pulses = 0;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Free-running edge counter
   always @(posedge clk) cyc <= cyc + 1;

   mvau_stream dut_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .in_v   (in_v),
      .in_act (in_act),
      .in_wgt (in_wgt),
      .out_v  (out_v),
      .out    (out)
   );

   bind mvau_stream_control mvau_stream_assert assert_i (
      .clk   (clk),
      .rst_n (rst_n),
      .in_v  (in_v),
      .ctrl  (ctrl),
      .state (state)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Mode 1 all -8, mode 2 a fixed +-7 pattern, otherwise random signed 4-bit
   function automatic int pick_value(input int mode, input int idx);
      if (mode == 1) return -8;
      if (mode == 2) return (idx % 3 == 0) ? -7 : 7;
      return int'($urandom_range(15, 0)) - 8;
   endfunction

   task automatic make_operands(input int mode);
      for (int c = 0; c < W; c++) begin
         vec[c] = pick_value(mode, c);
         for (int r = 0; r < H; r++) begin
            mat[r][c] = pick_value(mode, r + c + 1);
         end
      end
   endtask

   // Dot products of one row group wrapped to the accumulator width
   function automatic mvau_data_pkg::out_word_t model_group(input int nf);
      mvau_data_pkg::out_word_t res;
      int sum;
      for (int p = 0; p < PE; p++) begin
         sum = 0;
         for (int c = 0; c < W; c++) begin
            sum += vec[c] * mat[nf * PE + p][c];
         end
         res[p] = mvau_data_pkg::acc_t'(sum);
      end
      return res;
   endfunction

   // One step (nf, sf) that carries a first-pass chunk when v is set
   task automatic drive_step(input logic v, input int nf, input int sf);
      mvau_data_pkg::wgt_tile_t  tile;
      mvau_data_pkg::act_chunk_t chunk;
      for (int p = 0; p < PE; p++) begin
         for (int l = 0; l < SIMD; l++) begin
            tile[p][l] = mvau_data_pkg::wgt_t'(mat[nf * PE + p][sf * SIMD + l]);
         end
      end
      for (int l = 0; l < SIMD; l++) begin
         chunk[l] = mvau_data_pkg::act_t'(vec[sf * SIMD + l]);
      end
      @(posedge clk);
      in_v   <= v;
      in_act <= v ? chunk : mvau_data_pkg::act_chunk_t'($urandom);
      in_wgt <= tile;
      // Last chunk of a group makes a pulse 3 cycles on that is sampled one edge later
      if (sf == SF - 1) begin
         exp_q.push_back(model_group(nf));
         exp_cyc_q.push_back(cyc + 4);
      end
   endtask

   // First pass with random gaps, then replay weights every cycle
   task automatic run_vector(input int mode, input int max_gap);
      make_operands(mode);
      for (int sf = 0; sf < SF; sf++) begin
         if (sf > 0) begin
            repeat ($urandom_range(max_gap, 0)) begin
               @(posedge clk);
               in_v   <= 1'b0;
               in_act <= $urandom;
               in_wgt <= $urandom;
            end
         end
         drive_step(1'b1, 0, sf);
      end
      for (int nf = 1; nf < NF; nf++) begin
         for (int sf = 0; sf < SF; sf++) begin
            drive_step(1'b0, nf, sf);
         end
      end
   endtask

   // Result monitor that also catches pulses during and right after reset
   always @(posedge clk) begin
      if (dut_i.ctrl_i.assert_i.fail_cnt != 0) begin
         fail_run("A protocol assertion on the control block failed");
      end
      if (out_v === 1'b1) begin
         pulses++;
         if (exp_q.size() == 0) begin
            fail_run("out_v pulsed while no result was pending");
         end else begin
            check_equal("out", out, exp_q.pop_front());
            check_equal("out_v cycle", cyc, exp_cyc_q.pop_front());
         end
      end
   end

   initial begin
      void'($urandom(45));
      rst_n  = 1'b0;
      in_v   = 1'b0;
      in_act = '0;
      in_wgt = '0;
      repeat (RST_CYC) @(posedge clk);
      rst_n <= 1'b1;
      // Quiet interval where out_v must stay low
      repeat (5) @(posedge clk);
      // Single contiguous vector
      run_vector(0, 0);
      // Gapped first passes where each vector starts right after the last replay
      repeat (6) run_vector(0, 2);
      repeat (3) run_vector(0, 0);
      // Extreme operands
      run_vector(1, 1);
      run_vector(2, 0);
      // Last pulse lands 3 cycles after the final step with margin for stray pulses
      repeat (8) @(posedge clk);
      check_equal("out_v pulse count", pulses, NF * NUM_VEC);
      check_equal("pending results", exp_q.size(), 0);
      $display("Test OK");
      $finish;
   end

   // Watchdog sized from the vector count
   initial begin
      repeat (RST_CYC + 5 + NUM_VEC * (SF * NF + 2 * SF + 10)) @(posedge clk);
      fail_run("Timeout: watchdog expired before all results arrived");
   end

endmodule

//--- project.f
+incdir+logic
logic/mvau_data_pkg.sv
logic/mvau_ctrl_pkg.sv
logic/mvau_stream_control.sv
logic/mvau_inp_buffer.sv
logic/mvu_pe.sv
logic/mvau_stream.sv
testbench/mvau_stream_assert.sv
testbench/mvau_stream_tb.sv
